/* common/train_defs.svh */
`ifndef TRAIN_DEFS_SVH
`define TRAIN_DEFS_SVH

// --------------------------------------------------------------------------
// datapath geometry
// --------------------------------------------------------------------------

// lanes packed into one memory word
`define DATA_N 4

// Q8.8 words
`define N_LEN_W 16
`define F_LEN_W 8

// mixer hidden dimension
`define HID_DIM 8

// three HID_DIM x HID_DIM matrices, DATA_N weights per word
`define OPT_DEPTH (3 * `HID_DIM * `HID_DIM / `DATA_N)

// enough for OPT_DEPTH words
`define OPT_ADDR_W 6

// --------------------------------------------------------------------------
// optimizer coefficients, Q8.8
// --------------------------------------------------------------------------

// 0.875
`define MOMENTUM 16'sd224
// 0.0625
`define LR 16'sd16

`endif

/* common/fixed_pkg.sv */
`include "train_defs.svh"

package fixed_pkg;

  // one signed Q8.8 word
  typedef logic signed [`N_LEN_W-1:0] fixed_t;

  // full width product of two words, before truncation
  typedef logic signed [2*`N_LEN_W-1:0] prod_t;

  // one memory word, DATA_N lanes side by side
  // lane 0 sits in the low bits
  typedef struct packed {
    fixed_t [`DATA_N-1:0] lane;
  } lane_vec_t;

endpackage

/* common/optim_pkg.sv */
`include "train_defs.svh"

package optim_pkg;

  // sweep controller
  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    SWEEP = 2'd1,
    DONE  = 2'd2
  } ctrl_state_e;

  // memory picked by the host port
  typedef enum logic [1:0] {
    MEM_W = 2'd0,
    MEM_V = 2'd1,
    MEM_G = 2'd2
  } mem_sel_e;

  // one memory write
  typedef struct packed {
    logic                   en;
    logic [`OPT_ADDR_W-1:0] addr;
    fixed_pkg::lane_vec_t   data;
  } ram_wr_t;

  // host write, steered by sel
  typedef struct packed {
    mem_sel_e sel;
    ram_wr_t  wr;
  } host_wr_t;

endpackage

/* source/param_ram.sv */
`timescale 1ns/1ps
`include "train_defs.svh"

module param_ram (
  input  logic                   clk,
  input  optim_pkg::ram_wr_t     wr,
  input  logic [`OPT_ADDR_W-1:0] raddr_a,
  output fixed_pkg::lane_vec_t   rdata_a,
  input  logic [`OPT_ADDR_W-1:0] raddr_b,
  output fixed_pkg::lane_vec_t   rdata_b
);

  fixed_pkg::lane_vec_t mem [`OPT_DEPTH];

  // --------------------------------------------------------------------------
  // write port
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // --------------------------------------------------------------------------
  // read ports, one cycle latency
  // --------------------------------------------------------------------------

  // a: optimizer
  always_ff @(posedge clk) begin
    rdata_a <= mem[raddr_a];
  end

  // b: host
  // returns old data on a same-address write
  always_ff @(posedge clk) begin
    rdata_b <= mem[raddr_b];
  end

endmodule

/* optim/optim_ctrl.sv */
`timescale 1ns/1ps
`include "train_defs.svh"

module optim_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run,
  output logic [`OPT_ADDR_W-1:0] raddr,
  output logic [`OPT_ADDR_W-1:0] waddr,
  output logic                   wr_en,
  output logic                   valid
);

  localparam int LAST_WORD = `OPT_DEPTH - 1;
  localparam logic [`OPT_ADDR_W-1:0] LAST_ADDR = LAST_WORD[`OPT_ADDR_W-1:0];

  optim_pkg::ctrl_state_e state;

  // high while raddr holds a word that still has to be written back
  logic                   issue;
  logic [`OPT_ADDR_W-1:0] addr_d1;
  logic [`OPT_ADDR_W-1:0] addr_d2;
  logic                   issue_d1;
  logic                   issue_d2;

  // --------------------------------------------------------------------------
  // state
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= optim_pkg::IDLE;
    end else if (!run) begin
      state <= optim_pkg::IDLE;
    end else begin
      case (state)
        optim_pkg::IDLE: begin
          state <= optim_pkg::SWEEP;
        end
        optim_pkg::SWEEP: begin
          // last word lands on this edge
          if (wr_en && waddr == LAST_ADDR) begin
            state <= optim_pkg::DONE;
          end
        end
        default: begin
          state <= state;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // read address sequencer
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      raddr <= '0;
      issue <= 1'b0;
    end else if (!run) begin
      raddr <= '0;
      issue <= 1'b0;
    end else if (state == optim_pkg::IDLE) begin
      // word 0 is already on raddr
      issue <= 1'b1;
    end else if (issue) begin
      if (raddr == LAST_ADDR) begin
        issue <= 1'b0;
      end else begin
        raddr <= raddr + 1'b1;
      end
    end
  end

  // three stages, matching ram read plus two lane stages
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_d1  <= '0;
      addr_d2  <= '0;
      waddr    <= '0;
      issue_d1 <= 1'b0;
      issue_d2 <= 1'b0;
      wr_en    <= 1'b0;
    end else begin
      addr_d1  <= raddr;
      addr_d2  <= addr_d1;
      waddr    <= addr_d2;
      // dropping run flushes words still in flight
      issue_d1 <= issue & run;
      issue_d2 <= issue_d1 & run;
      wr_en    <= issue_d2 & run;
    end
  end

  assign valid = run && (state == optim_pkg::DONE);

endmodule

/* optim/momentum_lane.sv */
`timescale 1ns/1ps
`include "train_defs.svh"

module momentum_lane (
  input  logic              clk,
  input  logic              rst_n,
  input  fixed_pkg::fixed_t w,
  input  fixed_pkg::fixed_t v,
  input  fixed_pkg::fixed_t g,
  output fixed_pkg::fixed_t w_new,
  output fixed_pkg::fixed_t v_new
);

  localparam fixed_pkg::fixed_t MOMENTUM_C = `MOMENTUM;
  localparam fixed_pkg::fixed_t LR_C       = `LR;

  fixed_pkg::fixed_t mtm_q;
  fixed_pkg::fixed_t lr_q;
  fixed_pkg::fixed_t w_q;
  fixed_pkg::fixed_t v_diff;

  // Q8.8 times Q8.8, keep the middle word, no rounding
  function automatic fixed_pkg::fixed_t fixed_mul(input fixed_pkg::fixed_t a,
                                                  input fixed_pkg::fixed_t b);
    fixed_pkg::prod_t prod;
    prod = fixed_pkg::prod_t'(a) * fixed_pkg::prod_t'(b);
    return prod[`F_LEN_W +: `N_LEN_W];
  endfunction

  // stage one, both products and w delayed alongside
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtm_q <= '0;
      lr_q  <= '0;
      w_q   <= '0;
    end else begin
      mtm_q <= fixed_mul(MOMENTUM_C, v);
      lr_q  <= fixed_mul(LR_C, g);
      w_q   <= w;
    end
  end

  // new velocity, wraps at word width
  assign v_diff = mtm_q - lr_q;

  // stage two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v_new <= '0;
      w_new <= '0;
    end else begin
      v_new <= v_diff;
      w_new <= w_q + v_diff;
    end
  end

endmodule

/* optim/mix_optim_w.sv */
`timescale 1ns/1ps
`include "train_defs.svh"

module mix_optim_w (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run,
  output logic                   valid,
  output logic [`OPT_ADDR_W-1:0] raddr,
  input  fixed_pkg::lane_vec_t   rdata_w,
  input  fixed_pkg::lane_vec_t   rdata_v,
  input  fixed_pkg::lane_vec_t   rdata_g,
  output optim_pkg::ram_wr_t     upd_w,
  output optim_pkg::ram_wr_t     upd_v
);

  logic [`OPT_ADDR_W-1:0] waddr;
  logic                   wr_en;

  // per lane results, packed back into words below
  fixed_pkg::fixed_t w_res [`DATA_N];
  fixed_pkg::fixed_t v_res [`DATA_N];

  optim_ctrl ctrl_i (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .raddr (raddr),
    .waddr (waddr),
    .wr_en (wr_en),
    .valid (valid)
  );

  for (genvar i = 0; i < `DATA_N; i++) begin : g_lane
    momentum_lane lane_i (
      .clk   (clk),
      .rst_n (rst_n),
      .w     (rdata_w.lane[i]),
      .v     (rdata_v.lane[i]),
      .g     (rdata_g.lane[i]),
      .w_new (w_res[i]),
      .v_new (v_res[i])
    );
  end

  // W and V share address and strobe
  always_comb begin
    upd_w.en   = wr_en;
    upd_w.addr = waddr;
    upd_v.en   = wr_en;
    upd_v.addr = waddr;
    for (int i = 0; i < `DATA_N; i++) begin
      upd_w.data.lane[i] = w_res[i];
      upd_v.data.lane[i] = v_res[i];
    end
  end

endmodule

/* source/optim_top.sv */
`timescale 1ns/1ps
`include "train_defs.svh"

module optim_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   run,
  output logic                   valid,
  input  optim_pkg::host_wr_t    host_wr,
  input  optim_pkg::mem_sel_e    host_rd_sel,
  input  logic [`OPT_ADDR_W-1:0] host_rd_addr,
  output fixed_pkg::lane_vec_t   host_rd_data
);

  logic [`OPT_ADDR_W-1:0] raddr;

  fixed_pkg::lane_vec_t rdata_w;
  fixed_pkg::lane_vec_t rdata_v;
  fixed_pkg::lane_vec_t rdata_g;
  fixed_pkg::lane_vec_t host_w;
  fixed_pkg::lane_vec_t host_v;
  fixed_pkg::lane_vec_t host_g;

  optim_pkg::ram_wr_t upd_w;
  optim_pkg::ram_wr_t upd_v;
  optim_pkg::ram_wr_t host_wr_w;
  optim_pkg::ram_wr_t host_wr_v;
  optim_pkg::ram_wr_t host_wr_g;
  optim_pkg::ram_wr_t wr_w;
  optim_pkg::ram_wr_t wr_v;

  optim_pkg::mem_sel_e rd_sel_q;

  // keep the host write only for the selected memory
  function automatic optim_pkg::ram_wr_t host_pick(input optim_pkg::host_wr_t hw,
                                                   input optim_pkg::mem_sel_e sel);
    optim_pkg::ram_wr_t r;
    r    = hw.wr;
    r.en = hw.wr.en && (hw.sel == sel);
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // write steering
  // --------------------------------------------------------------------------
  always_comb begin
    host_wr_w = host_pick(host_wr, optim_pkg::MEM_W);
    host_wr_v = host_pick(host_wr, optim_pkg::MEM_V);
    host_wr_g = host_pick(host_wr, optim_pkg::MEM_G);
  end

  // optimizer owns W and V during a sweep
  assign wr_w = run ? upd_w : host_wr_w;
  assign wr_v = run ? upd_v : host_wr_v;

  // --------------------------------------------------------------------------
  // memories
  // --------------------------------------------------------------------------
  param_ram w_ram (
    .clk     (clk),
    .wr      (wr_w),
    .raddr_a (raddr),
    .rdata_a (rdata_w),
    .raddr_b (host_rd_addr),
    .rdata_b (host_w)
  );

  param_ram v_ram (
    .clk     (clk),
    .wr      (wr_v),
    .raddr_a (raddr),
    .rdata_a (rdata_v),
    .raddr_b (host_rd_addr),
    .rdata_b (host_v)
  );

  // gradients come from the host only
  param_ram g_ram (
    .clk     (clk),
    .wr      (host_wr_g),
    .raddr_a (raddr),
    .rdata_a (rdata_g),
    .raddr_b (host_rd_addr),
    .rdata_b (host_g)
  );

  mix_optim_w optim_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (run),
    .valid   (valid),
    .raddr   (raddr),
    .rdata_w (rdata_w),
    .rdata_v (rdata_v),
    .rdata_g (rdata_g),
    .upd_w   (upd_w),
    .upd_v   (upd_v)
  );

  // --------------------------------------------------------------------------
  // host read, select follows the address by one cycle
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_sel_q <= optim_pkg::MEM_W;
    end else begin
      rd_sel_q <= host_rd_sel;
    end
  end

  always_comb begin
    case (rd_sel_q)
      optim_pkg::MEM_W: host_rd_data = host_w;
      optim_pkg::MEM_V: host_rd_data = host_v;
      default:          host_rd_data = host_g;
    endcase
  end

endmodule

/* verification/optim_asserts.sv */
`timescale 1ns/1ps
`include "train_defs.svh"

module optim_asserts (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   run,
  input logic [`OPT_ADDR_W-1:0] raddr,
  input logic [`OPT_ADDR_W-1:0] waddr,
  input logic                   wr_en,
  input logic                   valid,
  input optim_pkg::ctrl_state_e state
);

  // write strobe only while sweeping
  wr_in_sweep: assert property (
    @(posedge clk) disable iff (!rst_n) wr_en |-> state == optim_pkg::SWEEP
  ) else $error("wr_en high outside a sweep");

  // write address trails the read address through ram and two lane stages
  waddr_delay: assert property (
    @(posedge clk) disable iff (!rst_n) wr_en |-> waddr == $past(raddr, 3)
  ) else $error("waddr does not match raddr from three cycles earlier");

  // valid follows run down
  valid_drop: assert property (
    @(posedge clk) disable iff (!rst_n) !run |=> !valid
  ) else $error("valid high in the cycle after run was low");

endmodule

/* verification/optim_tb.sv */
`timescale 1ns/1ps
`include "train_defs.svh"

module optim_tb;

  localparam int SWEEP_TIMEOUT = 4 * `OPT_DEPTH + 20;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   run;
  logic                   valid;
  optim_pkg::host_wr_t    host_wr;
  optim_pkg::mem_sel_e    host_rd_sel;
  logic [`OPT_ADDR_W-1:0] host_rd_addr;
  fixed_pkg::lane_vec_t   host_rd_data;

  int seed = 32'hbf69;

  // reference copies of the three memories
  fixed_pkg::lane_vec_t mw [`OPT_DEPTH];
  fixed_pkg::lane_vec_t mv [`OPT_DEPTH];
  fixed_pkg::lane_vec_t mg [`OPT_DEPTH];

  optim_top optim_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .valid        (valid),
    .host_wr      (host_wr),
    .host_rd_sel  (host_rd_sel),
    .host_rd_addr (host_rd_addr),
    .host_rd_data (host_rd_data)
  );

  bind optim_ctrl optim_asserts asserts_i (
    .clk   (clk),
    .rst_n (rst_n),
    .run   (run),
    .raddr (raddr),
    .waddr (waddr),
    .wr_en (wr_en),
    .valid (valid),
    .state (state)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------------
  task automatic abort_run(input string line);
    $display("%s", line);
    $display("sim failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_lane_vec(input fixed_pkg::lane_vec_t got, input fixed_pkg::lane_vec_t exp,
                                input string what);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_int(input int got, input int exp, input string what);
    if (got != exp) begin
      abort_run($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp));
    end
  endtask

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------

  // signed product, drop the low fraction bits, keep one word
  function automatic fixed_pkg::fixed_t q_mul(input fixed_pkg::fixed_t a,
                                              input fixed_pkg::fixed_t b);
    longint p;
    p = longint'(a) * longint'(b);
    p = p >>> `F_LEN_W;
    return p[`N_LEN_W-1:0];
  endfunction

  task automatic model_sweep();
    fixed_pkg::fixed_t vn;
    for (int a = 0; a < `OPT_DEPTH; a++) begin
      for (int l = 0; l < `DATA_N; l++) begin
        vn = q_mul(`MOMENTUM, mv[a].lane[l]) - q_mul(`LR, mg[a].lane[l]);
        mv[a].lane[l] = vn;
        mw[a].lane[l] = mw[a].lane[l] + vn;
      end
    end
  endtask

  function automatic fixed_pkg::fixed_t corner_val(input int i);
    case (i % 8)
      0:       return 16'h8000;
      1:       return 16'h7fff;
      2:       return 16'h00ff;
      3:       return 16'h0001;
      4:       return 16'hff01;
      5:       return 16'hffff;
      6:       return 16'h0080;
      default: return 16'hff80;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // host port tasks start and end 1 ns after a rising edge
  // --------------------------------------------------------------------------
  task automatic load_mem(input optim_pkg::mem_sel_e sel, input logic [`OPT_ADDR_W-1:0] addr,
                          input fixed_pkg::lane_vec_t data);
    host_wr.sel     = sel;
    host_wr.wr.addr = addr;
    host_wr.wr.data = data;
    host_wr.wr.en   = 1'b1;
    @(posedge clk);
    #1;
    host_wr.wr.en = 1'b0;
  endtask

  task automatic read_mem(input optim_pkg::mem_sel_e sel, input logic [`OPT_ADDR_W-1:0] addr,
                          output fixed_pkg::lane_vec_t data);
    host_rd_sel  = sel;
    host_rd_addr = addr;
    @(posedge clk);
    #1;
    data = host_rd_data;
  endtask

  // kind 0 gives random w with zero v and g
  // kind 1 is all random
  // kind 2 uses corner values
  task automatic load_all(input int kind);
    int rnd;
    int step;
    for (int a = 0; a < `OPT_DEPTH; a++) begin
      // lanes 0 and 1 together tell every corner word apart
      step = a / 8 + 1;
      for (int l = 0; l < `DATA_N; l++) begin
        if (kind == 2) begin
          mw[a].lane[l] = corner_val(a + l * step);
          mv[a].lane[l] = corner_val(a + 3 + l * (step + 1));
          mg[a].lane[l] = corner_val(a + 5 + l * (step + 2));
        end else begin
          rnd = $random(seed);
          mw[a].lane[l] = rnd[15:0];
          rnd = $random(seed);
          mv[a].lane[l] = (kind == 0) ? 16'h0000 : rnd[15:0];
          rnd = $random(seed);
          mg[a].lane[l] = (kind == 0) ? 16'h0000 : rnd[15:0];
        end
      end
    end
    for (int a = 0; a < `OPT_DEPTH; a++) begin
      load_mem(optim_pkg::MEM_W, `OPT_ADDR_W'(a), mw[a]);
      load_mem(optim_pkg::MEM_V, `OPT_ADDR_W'(a), mv[a]);
      load_mem(optim_pkg::MEM_G, `OPT_ADDR_W'(a), mg[a]);
    end
  endtask

  task automatic verify_all();
    fixed_pkg::lane_vec_t got;
    for (int a = 0; a < `OPT_DEPTH; a++) begin
      read_mem(optim_pkg::MEM_W, `OPT_ADDR_W'(a), got);
      check_lane_vec(got, mw[a], $sformatf("W word %0d", a));
      read_mem(optim_pkg::MEM_V, `OPT_ADDR_W'(a), got);
      check_lane_vec(got, mv[a], $sformatf("V word %0d", a));
    end
  endtask

  // raise run and wait for valid, then hold and drop run
  task automatic run_sweep(input int hold);
    int n;
    n   = 0;
    run = 1'b1;
    do begin
      @(posedge clk);
      #1;
      n++;
      if (n > SWEEP_TIMEOUT) begin
        abort_run($sformatf("timeout: valid did not rise within %0d cycles", SWEEP_TIMEOUT));
      end
    end while (!valid);
    // the first edge in the loop is edge 0
    check_int(n - 1, `OPT_DEPTH + 3, "edges from run to valid");
    repeat (hold) begin
      @(posedge clk);
      #1;
      check_bit(valid, 1'b1, "valid while run is held");
    end
    run = 1'b0;
    @(posedge clk);
    #1;
    check_bit(valid, 1'b0, "valid after run drops");
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic idle_after_reset();
    check_bit(valid, 1'b0, "valid after reset");
    repeat (6) begin
      @(posedge clk);
      #1;
      check_bit(valid, 1'b0, "valid while run is low");
    end
  endtask

  task automatic zero_grad_sweep();
    load_all(0);
    run_sweep(0);
    // with zero v and g the model arrays already hold the answer
    verify_all();
  endtask

  task automatic random_sweep();
    load_all(1);
    run_sweep(0);
    model_sweep();
    verify_all();
  endtask

  task automatic valid_timing();
    load_all(1);
    run_sweep(5);
    model_sweep();
    verify_all();
  endtask

  task automatic momentum_accumulates();
    load_all(1);
    run_sweep(0);
    run_sweep(0);
    model_sweep();
    model_sweep();
    verify_all();
  endtask

  task automatic corner_values();
    load_all(2);
    run_sweep(0);
    model_sweep();
    verify_all();
  endtask

  initial begin
    rst_n        = 1'b0;
    run          = 1'b0;
    host_wr      = '0;
    host_rd_sel  = optim_pkg::MEM_W;
    host_rd_addr = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    idle_after_reset();
    zero_grad_sweep();
    random_sweep();
    valid_timing();
    momentum_accumulates();
    corner_values();

    $display("sim passed");
    $finish;
  end

endmodule

/* files.f */
+incdir+common
common/fixed_pkg.sv
common/optim_pkg.sv
source/param_ram.sv
optim/optim_ctrl.sv
optim/momentum_lane.sv
optim/mix_optim_w.sv
source/optim_top.sv
verification/optim_asserts.sv
verification/optim_tb.sv

/* run.sh */
#!/bin/sh
# build and run the optimizer testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module optim_tb -f files.f -o optim_sim &&
./obj_dir/optim_sim || exit 1
